// ==== all.f ====
design/fpu_pkg.sv
design/fp_decode.sv
design/fp_reg_status.sv
design/fp_add_core.sv
design/fadd_fsub.sv
design/fp_result.sv
design/fp_unit_top.sv
bench/fp_unit_checker.sv
bench/fp_unit_tb.sv

// ==== bench/fp_unit_checker.sv ====
`timescale 1ns/1ps

module fp_unit_checker #(
	parameter int ROB_WIDTH = fpu_pkg::ROB_WIDTH_DEF
) (
	input logic clk,
	input logic reset,
	input logic inst_valid,
	input logic inst_ready,
	input fpu_pkg::cdb_t cdb,
	input logic cdb_ready,
	input logic exp_valid,
	input logic [ROB_WIDTH-1:0] exp_tag,
	input logic [31:0] exp_data,
	input logic ordered,
	input int test_id,
	input logic test_end,
	input logic final_req,
	output int errors,
	output int outstanding
);
	import fpu_pkg::*;

	logic pend [2**ROB_WIDTH];
	logic [31:0] want [2**ROB_WIDTH];
	logic [ROB_WIDTH-1:0] next_tag;
	logic stalled;
	cdb_t held;
	int inflight, checks, t_checks, t_errors, tests;

	task automatic flag();
		errors++;
		t_errors++;
	endtask

	always @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 2**ROB_WIDTH; i++) pend[i] = 1'b0;
			next_tag = '0;
			stalled = 1'b0;
			held = '0;
			inflight = 0;
			checks = 0;
			t_checks = 0;
			t_errors = 0;
			tests = 0;
			errors = 0;
			outstanding = 0;
		end else begin
			if (stalled && cdb != held) begin
				$display("** Error @ %0t: bus changed from %h to %h while stalled", $time, held, cdb);
				flag();
			end
			if (inflight > 3 || (inflight == 3 && !cdb_ready && inst_ready)) begin
				$display("inst_ready stayed high with %0d instructions in flight", inflight);
				flag();
			end
			if (cdb.valid && cdb_ready) begin
				if (!pend[cdb.tag]) begin
					$display("a result came back for tag %0d that was not expected", cdb.tag);
					flag();
				end else begin
					checks++;
					t_checks++;
					if (cdb.data != want[cdb.tag]) begin
						$display("** Error @ %0t: tag %0d gave %h, expected %h", $time, cdb.tag,
							cdb.data, want[cdb.tag]);
						flag();
					end
					pend[cdb.tag] = 1'b0;
					outstanding--;
				end
				if (ordered && cdb.tag != next_tag) begin
					$display("** Error @ %0t: tag %0d out of order, expected %0d", $time, cdb.tag,
						next_tag);
					flag();
				end
				next_tag = next_tag + 1'b1;
			end
			if (exp_valid) begin
				pend[exp_tag] = 1'b1;
				want[exp_tag] = exp_data;
				outstanding++;
			end
			inflight = inflight + int'(inst_valid && inst_ready) - int'(cdb.valid && cdb_ready);
			stalled = cdb.valid && !cdb_ready;
			held = cdb;
			if (test_end) begin
				$display("test %0d: %0d results checked, %0d errors", test_id, t_checks, t_errors);
				tests++;
				t_checks = 0;
				t_errors = 0;
			end
			if (final_req) begin
				for (int i = 0; i < 2**ROB_WIDTH; i++) begin
					if (pend[i]) begin
						$display("the result for tag %0d never came back", i);
						errors++;
					end
				end
				$display("%0d tests, %0d results checked, %0d errors", tests, checks, errors);
			end
		end
	end

endmodule

// ==== bench/fp_unit_tb.sv ====
`timescale 1ns/1ps

module fp_unit_tb;
	import fpu_pkg::*;

	localparam int N_INST = 16 + 60 + 12 + 60 + 8;

	logic clk, reset, inst_valid, inst_ready, cdb_ready;
	fp_inst_u inst;
	cdb_t cdb;
	logic exp_valid, test_end, final_req, ordered, bp_random;
	logic [ROB_WIDTH_DEF-1:0] exp_tag, tag_cnt;
	logic [31:0] exp_data;
	logic [31:0] regs [32];
	int test_id, errors, outstanding, bp_run;
	int last [4];

	fp_unit_top #(.ROB_WIDTH(ROB_WIDTH_DEF), .N_FPR(N_FPR_DEF)) dut (
		.clk(clk), .reset(reset), .inst_valid(inst_valid), .inst(inst),
		.inst_ready(inst_ready), .cdb(cdb), .cdb_ready(cdb_ready)
	);

	fp_unit_checker #(.ROB_WIDTH(ROB_WIDTH_DEF)) u_checker (
		.clk(clk), .reset(reset), .inst_valid(inst_valid), .inst_ready(inst_ready),
		.cdb(cdb), .cdb_ready(cdb_ready), .exp_valid(exp_valid), .exp_tag(exp_tag),
		.exp_data(exp_data), .ordered(ordered), .test_id(test_id), .test_end(test_end),
		.final_req(final_req), .errors(errors), .outstanding(outstanding)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// --------------------------------------------------
	// reference adder, written from the flush/align/truncate rule
	// --------------------------------------------------
	function automatic logic [31:0] fp_model(input logic [31:0] a, input logic [31:0] b,
			input logic sub);
		logic sa, sb, sl, ss;
		int ka, kb, el, es, ml, ms, r;
		sa = a[31];
		sb = b[31] ^ sub;
		ka = (a[30:23] == 8'd0) ? 0 : int'(a[30:0]);
		kb = (b[30:23] == 8'd0) ? 0 : int'(b[30:0]);
		if (kb > ka) begin
			sl = sb;
			ss = sa;
			ml = kb;
			ms = ka;
		end else begin
			sl = sa;
			ss = sb;
			ml = ka;
			ms = kb;
		end
		el = ml >> 23;
		es = ms >> 23;
		ml = (ml == 0) ? 0 : ((ml & 32'h007f_ffff) | 32'h0080_0000);
		ms = (ms == 0) ? 0 : ((ms & 32'h007f_ffff) | 32'h0080_0000);
		ms = (el - es > 23) ? 0 : (ms >> (el - es));
		r = (sl == ss) ? ml + ms : ml - ms;
		if (r == 0) return {sl & ss, 31'd0};
		if (r >= 32'h0100_0000) begin
			r = r >> 1;
			el++;
		end
		while (r < 32'h0080_0000) begin
			r = r << 1;
			el--;
		end
		if (el < 1) return {sl, 31'd0}; // underflow gives a signed zero.
		return {sl, 8'(el), 23'(r)};
	endfunction

	function automatic logic [31:0] reg_word(input logic [5:0] op, input int rd, input int rs1,
			input int rs2);
		return {op, 5'(rd), 5'(rs1), 5'(rs2), 11'd0};
	endfunction

	function automatic logic [31:0] imm_word(input int rd, input logic [15:0] imm);
		return {OP_FLI, 5'(rd), 5'd0, imm};
	endfunction

	function automatic logic [15:0] rand_imm();
		return {1'($urandom), 8'(100 + $urandom % 31), 7'($urandom)}; // keeps sums far from overflow.
	endfunction

	// holds the word until the DUT takes it, then updates the model.
	task automatic send(input logic [31:0] word);
		logic done;
		logic [31:0] res;
		done = 1'b0;
		inst_valid = 1'b1;
		inst = word;
		while (!done) begin
			#1;
			if (inst_ready) begin
				done = 1'b1;
				if (word[31:26] == OP_FLI) begin
					res = fp_model({word[15:0], 16'h0000}, 32'h0, 1'b0);
				end else begin
					res = fp_model(regs[word[20:16]], regs[word[15:11]], word[26]);
				end
				regs[word[25:21]] = res;
				exp_valid = 1'b1;
				exp_tag = tag_cnt;
				exp_data = res;
				tag_cnt = tag_cnt + 1'b1;
			end
			@(negedge clk);
			exp_valid = 1'b0;
		end
		inst_valid = 1'b0;
	endtask

	task automatic finish_test();
		while (outstanding != 0) @(negedge clk);
		test_end = 1'b1;
		@(negedge clk);
		test_end = 1'b0;
		ordered = 1'b0;
	endtask

	task automatic random_op(input int rd, input int rs1, input int rs2);
		send(reg_word(($urandom % 2 == 0) ? OP_FADD : OP_FSUB, rd, rs1, rs2));
	endtask

	// cdb_ready runs of random length while back-pressure is on.
	always @(negedge clk) begin
		if (bp_random) begin
			if (bp_run == 0) begin
				cdb_ready = ($urandom % 2) == 0;
				bp_run = 1 + $urandom % 6;
			end
			bp_run--;
		end
	end

	// --------------------------------------------------
	// stimulus
	// --------------------------------------------------
	initial begin
		void'($urandom(32'h11c3));
		reset = 1'b1;
		inst_valid = 1'b0;
		inst = '0;
		cdb_ready = 1'b1;
		bp_random = 1'b0;
		bp_run = 0;
		exp_valid = 1'b0;
		exp_tag = '0;
		exp_data = '0;
		test_end = 1'b0;
		final_req = 1'b0;
		ordered = 1'b0;
		test_id = 0;
		tag_cnt = '0;
		for (int i = 0; i < 32; i++) regs[i] = 32'h0;
		for (int i = 0; i < 4; i++) last[i] = 12 + i;
		repeat (10) @(negedge clk);
		reset = 1'b0;

		test_id = 1;
		ordered = 1'b1;
		for (int i = 0; i < 16; i++) send(imm_word(i, rand_imm()));
		finish_test();

		test_id = 2;
		for (int i = 0; i < 60; i++) begin
			if ($urandom % 4 == 0) @(negedge clk);
			last[i % 4] = $urandom % 16;
			random_op(last[i % 4], last[$urandom % 4], last[$urandom % 4]);
		end
		finish_test();

		test_id = 3;
		for (int k = 0; k < 4; k++) begin
			cdb_ready = 1'b0; // first result parks in the result stage.
			send(imm_word(20, rand_imm()));
			send(reg_word(OP_FADD, 21, 20, 20));
			send(imm_word(22, rand_imm()));
			repeat (3) @(negedge clk);
			cdb_ready = 1'b1;
			while (outstanding != 0) @(negedge clk);
		end
		finish_test();

		test_id = 4;
		bp_random = 1'b1;
		for (int i = 0; i < 60; i++) begin
			if ($urandom % 4 == 0) send(imm_word($urandom % 16, rand_imm()));
			else random_op($urandom % 16, $urandom % 16, $urandom % 16);
		end
		bp_random = 1'b0;
		cdb_ready = 1'b1;
		finish_test();

		test_id = 5;
		send(imm_word(1, 16'h4321));
		send(reg_word(OP_FSUB, 2, 1, 1)); // equal operands.
		send(imm_word(3, 16'h4b00));
		send(imm_word(4, 16'h3f00));
		send(reg_word(OP_FADD, 5, 3, 4)); // exponent gap of 24.
		send(imm_word(6, 16'h0040)); // zero exponent, flushed.
		send(reg_word(OP_FADD, 7, 1, 6));
		send(reg_word(OP_FSUB, 8, 6, 6));
		finish_test();

		final_req = 1'b1;
		@(negedge clk);
		final_req = 1'b0;
		@(negedge clk);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

	initial begin
		#(N_INST * 20 * 40 + 10 * 40);
		$display("timeout: the DUT stopped taking instructions or returning results");
		$display("Checks failed");
		$finish;
	end

endmodule

// ==== design/fadd_fsub.sv ====
`timescale 1ns/1ps

module fadd_fsub #(
	parameter int ROB_WIDTH = fpu_pkg::ROB_WIDTH_DEF
) (
	input logic clk,
	input logic reset,
	input fpu_pkg::issue_t issue,
	input fpu_pkg::cdb_t [1:0] opd,
	input fpu_pkg::cdb_t cdb,
	output logic issue_ready,
	input logic result_ready,
	output fpu_pkg::cdb_t exec
);
	import fpu_pkg::*;

	localparam int N_ENTRY = 2;

	typedef struct packed {
		logic valid;
		logic [ROB_WIDTH-1:0] tag;
		logic is_fsub;
		cdb_t [1:0] opd;
	} entry_t;

	entry_t e [N_ENTRY]; // filled from index 0.
	entry_t e_upd [N_ENTRY];
	entry_t e_new;
	logic [N_ENTRY-1:0] rdy;
	logic sel;
	logic dispatch;
	logic [31:0] sum;

	// --------------------------------------------------
	// new entry and CDB wakeup
	// --------------------------------------------------
	always_comb begin
		e_new.valid = issue.valid;
		e_new.tag = issue.tag;
		e_new.is_fsub = issue.is_fsub;
		if (issue.use_imm) begin
			e_new.opd[0] = '{valid: 1'b1, tag: '0, data: issue.imm};
			e_new.opd[1] = '{valid: 1'b1, tag: '0, data: 32'h0000_0000}; // plus +0.0.
		end else begin
			e_new.opd = opd;
		end
	end

	always_comb begin
		for (int i = 0; i < N_ENTRY; i++) begin
			e_upd[i] = e[i];
			for (int j = 0; j < 2; j++) begin
				if (!e[i].opd[j].valid && cdb.valid && cdb.tag == e[i].opd[j].tag) begin
					e_upd[i].opd[j].valid = 1'b1;
					e_upd[i].opd[j].data = cdb.data;
				end
			end
		end
	end

	// --------------------------------------------------
	// dispatch select
	// --------------------------------------------------
	always_comb begin
		for (int i = 0; i < N_ENTRY; i++) begin
			rdy[i] = e[i].valid && e[i].opd[0].valid && e[i].opd[1].valid;
		end
	end

	assign sel = !rdy[0]; // entry 0 is older and goes first.
	assign dispatch = (|rdy) && result_ready;
	assign issue_ready = dispatch || !e[N_ENTRY-1].valid;

	always_ff @(posedge clk) begin
		if (reset) begin
			e[0].valid <= 1'b0;
			e[1].valid <= 1'b0;
		end else if (dispatch) begin
			if (!sel) begin
				e[0] <= e[1].valid ? e_upd[1] : e_new;
			end else begin
				e[0] <= e_upd[0];
			end
			e[1] <= e_new; // empty unless an issue arrives.
			if (!e[1].valid) begin
				e[1].valid <= 1'b0;
			end
		end else begin
			e[0] <= e[0].valid ? e_upd[0] : e_new;
			e[1] <= e[1].valid ? e_upd[1] : e_new;
			if (!e[0].valid && !e[1].valid) begin
				e[1].valid <= 1'b0;
			end
		end
	end

	fp_add_core u_add (
		.a(e[sel].opd[0].data),
		.b(e[sel].opd[1].data),
		.sub(e[sel].is_fsub),
		.sum(sum)
	);

	assign exec = '{valid: dispatch, tag: e[sel].tag, data: sum};

endmodule

// ==== design/fp_add_core.sv ====
`timescale 1ns/1ps

module fp_add_core (
	input logic [31:0] a,
	input logic [31:0] b,
	input logic sub,
	output logic [31:0] sum
);

	logic sa, sb;
	logic [30:0] mag_a, mag_b;
	logic s_l, s_s;
	logic [7:0] e_l, e_s, diff;
	logic [23:0] m_l, m_s, m_align;
	logic eff_sub;
	logic [24:0] raw;
	logic [4:0] lz;
	logic [23:0] norm;
	logic signed [9:0] exp_n;
	logic [22:0] frac;
	logic zero_sign;

	// --------------------------------------------------
	// unpack, flush and order by magnitude
	// --------------------------------------------------
	assign sa = a[31];
	assign sb = b[31] ^ sub;
	assign mag_a = (a[30:23] == 8'd0) ? 31'd0 : a[30:0]; // zero exponent flushes.
	assign mag_b = (b[30:23] == 8'd0) ? 31'd0 : b[30:0];

	always_comb begin
		if (mag_b > mag_a) begin
			s_l = sb;
			s_s = sa;
			e_l = mag_b[30:23];
			e_s = mag_a[30:23];
			m_l = {1'b1, mag_b[22:0]};
			m_s = (mag_a == 31'd0) ? 24'd0 : {1'b1, mag_a[22:0]};
		end else begin
			s_l = sa;
			s_s = sb;
			e_l = mag_a[30:23];
			e_s = mag_b[30:23];
			m_l = (mag_a == 31'd0) ? 24'd0 : {1'b1, mag_a[22:0]};
			m_s = (mag_b == 31'd0) ? 24'd0 : {1'b1, mag_b[22:0]};
		end
	end

	// --------------------------------------------------
	// align and add
	// --------------------------------------------------
	assign diff = e_l - e_s;
	assign m_align = (diff > 8'd23) ? 24'd0 : (m_s >> diff); // shifted-out bits drop.
	assign eff_sub = s_l ^ s_s;
	assign raw = eff_sub ? ({1'b0, m_l} - {1'b0, m_align}) : ({1'b0, m_l} + {1'b0, m_align});
	assign zero_sign = s_l & s_s;

	always_comb begin
		lz = 5'd24;
		for (int i = 0; i < 24; i++) begin
			if (raw[i]) begin
				lz = 5'(23 - i); // the highest set bit is found last.
			end
		end
	end

	always_comb begin
		norm = raw[23:0] << lz;
		if (raw[24]) begin
			exp_n = $signed({2'b00, e_l}) + 10'sd1;
			frac = raw[23:1];
		end else begin
			exp_n = $signed({2'b00, e_l}) - $signed({5'd0, lz});
			frac = norm[22:0];
		end
	end

	// exact zero and underflow both give a signed zero.
	assign sum = (raw == 25'd0) ? {zero_sign, 31'd0} :
	             (exp_n < 10'sd1) ? {s_l, 31'd0} :
	             {s_l, exp_n[7:0], frac};

endmodule

// ==== design/fp_decode.sv ====
`timescale 1ns/1ps

module fp_decode #(
	parameter int ROB_WIDTH = fpu_pkg::ROB_WIDTH_DEF
) (
	input logic clk,
	input logic reset,
	input logic inst_valid,
	input fpu_pkg::fp_inst_u inst,
	input logic issue_ready,
	output fpu_pkg::issue_t issue
);
	import fpu_pkg::*;

	logic [ROB_WIDTH-1:0] tag_cnt;

	always_comb begin
		issue = '0;
		issue.valid = inst_valid && issue_ready;
		issue.tag = tag_cnt;
		issue.is_fsub = inst.rf.op[0];
		issue.rd = inst.rf.rd; // same bits in both views.
		case (inst.rf.op)
			OP_FLI: begin
				issue.use_imm = 1'b1;
				issue.imm = {inst.imf.imm16, 16'h0000}; // upper half of the float.
			end
			OP_FADD, OP_FSUB: begin
				issue.rs[0] = inst.rf.rs1;
				issue.rs[1] = inst.rf.rs2;
			end
			default: begin
				// unknown opcodes add r0 to itself.
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			tag_cnt <= '0;
		end else if (issue.valid) begin
			tag_cnt <= tag_cnt + 1'b1; // wraps at the tag width.
		end
	end

endmodule

// ==== design/fp_reg_status.sv ====
`timescale 1ns/1ps

module fp_reg_status #(
	parameter int ROB_WIDTH = fpu_pkg::ROB_WIDTH_DEF,
	parameter int N_FPR = fpu_pkg::N_FPR_DEF
) (
	input logic clk,
	input logic reset,
	input fpu_pkg::issue_t issue,
	input fpu_pkg::cdb_t cdb,
	output fpu_pkg::cdb_t [1:0] opd
);

	logic [31:0] value [N_FPR];
	logic pend [N_FPR];
	logic [ROB_WIDTH-1:0] ptag [N_FPR];

	// --------------------------------------------------
	// read ports with bypass from the broadcast
	// --------------------------------------------------
	always_comb begin
		for (int j = 0; j < 2; j++) begin
			opd[j].valid = 1'b1;
			opd[j].tag = ptag[issue.rs[j]];
			opd[j].data = value[issue.rs[j]];
			if (pend[issue.rs[j]]) begin
				if (cdb.valid && cdb.tag == ptag[issue.rs[j]]) begin
					opd[j].data = cdb.data; // producer finishes this cycle.
				end else begin
					opd[j].valid = 1'b0;
				end
			end
		end
	end

	// --------------------------------------------------
	// pending marks and write-back
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < N_FPR; i++) begin
				pend[i] <= 1'b0;
				value[i] <= 32'h0000_0000;
			end
		end else begin
			for (int i = 0; i < N_FPR; i++) begin
				if (issue.valid && issue.rd == 5'(i)) begin
					pend[i] <= 1'b1; // a new producer overrides the write-back.
					ptag[i] <= issue.tag;
				end else if (cdb.valid && pend[i] && ptag[i] == cdb.tag) begin
					pend[i] <= 1'b0;
					value[i] <= cdb.data;
				end
			end
		end
	end

endmodule

// ==== design/fp_result.sv ====
`timescale 1ns/1ps

module fp_result #(
	parameter int ROB_WIDTH = fpu_pkg::ROB_WIDTH_DEF
) (
	input logic clk,
	input logic reset,
	input fpu_pkg::cdb_t exec,
	output logic result_ready,
	input logic cdb_ready,
	output fpu_pkg::cdb_t cdb,
	output fpu_pkg::cdb_t bcast
);

	logic r_valid;
	logic [ROB_WIDTH-1:0] r_tag;
	logic [31:0] r_data;

	assign result_ready = !r_valid || cdb_ready; // empty, or draining this cycle.

	always_ff @(posedge clk) begin
		if (reset) begin
			r_valid <= 1'b0;
		end else if (result_ready) begin
			r_valid <= exec.valid;
			r_tag <= exec.tag;
			r_data <= exec.data;
		end
	end

	assign cdb = '{valid: r_valid, tag: r_tag, data: r_data};
	assign bcast = '{valid: r_valid && cdb_ready, tag: r_tag, data: r_data};

endmodule

// ==== design/fp_unit_top.sv ====
`timescale 1ns/1ps

module fp_unit_top #(
	parameter int ROB_WIDTH = fpu_pkg::ROB_WIDTH_DEF,
	parameter int N_FPR = fpu_pkg::N_FPR_DEF
) (
	input logic clk,
	input logic reset,
	input logic inst_valid,
	input fpu_pkg::fp_inst_u inst,
	output logic inst_ready,
	output fpu_pkg::cdb_t cdb,
	input logic cdb_ready
);
	import fpu_pkg::*;

	issue_t issue;
	cdb_t [1:0] opd;
	cdb_t exec;
	cdb_t bcast; // the accepted beat, seen by every waiting operand.
	logic result_ready;

	fp_decode #(
		.ROB_WIDTH(ROB_WIDTH)
	) u_decode (
		.clk(clk),
		.reset(reset),
		.inst_valid(inst_valid),
		.inst(inst),
		.issue_ready(inst_ready),
		.issue(issue)
	);

	fp_reg_status #(
		.ROB_WIDTH(ROB_WIDTH),
		.N_FPR(N_FPR)
	) u_reg_status (
		.clk(clk),
		.reset(reset),
		.issue(issue),
		.cdb(bcast),
		.opd(opd)
	);

	fadd_fsub #(
		.ROB_WIDTH(ROB_WIDTH)
	) u_fadd_fsub (
		.clk(clk),
		.reset(reset),
		.issue(issue),
		.opd(opd),
		.cdb(bcast),
		.issue_ready(inst_ready),
		.result_ready(result_ready),
		.exec(exec)
	);

	fp_result #(
		.ROB_WIDTH(ROB_WIDTH)
	) u_result (
		.clk(clk),
		.reset(reset),
		.exec(exec),
		.result_ready(result_ready),
		.cdb_ready(cdb_ready),
		.cdb(cdb),
		.bcast(bcast)
	);

endmodule

// ==== design/fpu_pkg.sv ====
package fpu_pkg;

	localparam int ROB_WIDTH_DEF = 4;
	localparam int N_FPR_DEF = 32;

	// bit 0 of the opcode is the subtract flag.
	localparam logic [5:0] OP_FADD = 6'd0;
	localparam logic [5:0] OP_FSUB = 6'd1;
	localparam logic [5:0] OP_FLI = 6'd2;

	typedef struct packed {
		logic [5:0] op;
		logic [4:0] rd;
		logic [4:0] rs1;
		logic [4:0] rs2;
		logic [10:0] unused;
	} fp_inst_reg_t;

	typedef struct packed {
		logic [5:0] op;
		logic [4:0] rd;
		logic [4:0] unused;
		logic [15:0] imm16;
	} fp_inst_imm_t;

	typedef union packed {
		fp_inst_reg_t rf;
		fp_inst_imm_t imf;
	} fp_inst_u;

	typedef struct packed {
		logic valid;
		logic [ROB_WIDTH_DEF-1:0] tag;
		logic [31:0] data;
	} cdb_t;

	typedef struct packed {
		logic valid;
		logic [ROB_WIDTH_DEF-1:0] tag;
		logic is_fsub;
		logic [4:0] rd;
		logic [1:0][4:0] rs;
		logic use_imm;
		logic [31:0] imm;
	} issue_t;

endpackage

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f all.f --top-module fp_unit_tb --Mdir obj_dir -o fp_sim
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

out=$(./obj_dir/fp_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "All checks passed"; then
	exit 0
fi
exit 1
